// File: hw/trdb_cfg_pkg.sv
// ********************************************************
// trace encoder core side definitions
// widths, decoded opcodes and the retired instruction record
// ********************************************************
`default_nettype none

package trdb_cfg_pkg;

    localparam int XLEN      = 32;
    localparam int INST_LEN  = 32;
    localparam int CAUSE_LEN = 5;
    localparam int PRIV_LEN  = 2;

    // major opcodes the encoder tells apart
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } trdb_opcode_e;

    // one retired instruction as reported by the core
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  data;
        logic [PRIV_LEN-1:0]  priv;
        logic                 exception;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
    } trdb_inst_t;

    // pipeline entry for nc, tc and lc
    typedef struct packed {
        trdb_inst_t inst;
        logic       valid;
        // trace enable seen with this instruction
        logic       qualified;
    } trdb_stage_t;

endpackage

`default_nettype wire

// File: hw/trdb_pkt_pkg.sv
// ********************************************************
// trace packet definitions
// formats, branch map sizes and the emitted packet layout
// ********************************************************
`default_nettype none

package trdb_pkt_pkg;

    // branch map depth and the width of its count
    localparam int BRANCH_MAP_LEN   = 31;
    localparam int BRANCH_COUNT_LEN = 5;

    // packet format, value 0 not produced
    typedef enum logic [1:0] {
        FMT_BRANCH_FULL = 2'd1,
        FMT_ADDR        = 2'd2,
        FMT_SYNC        = 2'd3
    } trdb_format_e;

    // sync subformat
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_e;

    // emitted packet
    // fields unused by a format are zero
    typedef struct packed {
        trdb_format_e                       format;
        trdb_sync_e                         subformat;
        logic [trdb_cfg_pkg::PRIV_LEN-1:0]  priv;
        logic                               interrupt;
        logic [trdb_cfg_pkg::CAUSE_LEN-1:0] cause;
        logic [trdb_cfg_pkg::XLEN-1:0]      address;
        // branches recorded since the last packet
        logic [BRANCH_COUNT_LEN-1:0]        branches;
        // one bit per branch, set for not taken
        logic [BRANCH_MAP_LEN-1:0]          branch_map;
    } trdb_packet_t;

endpackage

`default_nettype wire

// File: hw/trdb_itype_detector.sv
// ********************************************************
// instruction type detector
// flags branch, taken and uninferable jump for the tc slot
// ********************************************************
`timescale 1ns/1ps
`default_nettype none

module trdb_itype_detector (
    input  logic [trdb_cfg_pkg::INST_LEN-1:0] tc_data_i,
    input  logic [trdb_cfg_pkg::XLEN-1:0]     tc_pc_i,
    input  logic [trdb_cfg_pkg::XLEN-1:0]     nc_pc_i,
    output logic                              branch_o,
    output logic                              taken_o,
    output logic                              updiscon_o
);

    logic [6:0]                      opcode;
    logic [trdb_cfg_pkg::XLEN-1:0]   seq_pc;

    // major opcode, low two bits included
    assign opcode = tc_data_i[6:0];

    // fall-through address, no compressed instructions
    assign seq_pc = tc_pc_i + 'd4;

    always_comb begin
        branch_o   = 1'b0;
        updiscon_o = 1'b0;
        case (opcode)
            trdb_cfg_pkg::OPC_BRANCH: begin
                branch_o = 1'b1;
            end
            // target comes from a register
            trdb_cfg_pkg::OPC_JALR: begin
                updiscon_o = 1'b1;
            end
            // jal target is inferable from the binary
            trdb_cfg_pkg::OPC_JAL: begin
            end
            default: begin
            end
        endcase
    end

    // successor not at pc+4 means the branch went
    assign taken_o = branch_o && (nc_pc_i != seq_pc);

endmodule

`default_nettype wire

// File: hw/trdb_branch_map.sv
// ********************************************************
// branch map
// collects taken/not-taken bits of traced branches
// ********************************************************
`timescale 1ns/1ps
`default_nettype none

module trdb_branch_map (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      record_i,
    input  logic                                      taken_i,
    input  logic                                      flush_i,
    output logic [trdb_pkt_pkg::BRANCH_MAP_LEN-1:0]   map_o,
    output logic [trdb_pkt_pkg::BRANCH_COUNT_LEN-1:0] count_o,
    output logic                                      full_o
);

    logic [trdb_pkt_pkg::BRANCH_MAP_LEN-1:0]   map_q;
    logic [trdb_pkt_pkg::BRANCH_COUNT_LEN-1:0] count_q;

    // view of the map with this cycle's record folded in
    always_comb begin
        map_o   = map_q;
        count_o = count_q;
        if (record_i) begin
            // not taken is stored as one
            map_o[count_q] = ~taken_i;
            count_o        = count_q + 1'b1;
        end
    end

    assign full_o = (count_o == trdb_pkt_pkg::BRANCH_MAP_LEN);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // record of this cycle already went out with the packet
            map_q   <= '0;
            count_q <= '0;
        end else if (record_i) begin
            map_q   <= map_o;
            count_q <= count_o;
        end
    end

    // a full map is always flushed by a packet in the same cycle
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        full_o |-> flush_i
    ) else $error("branch map full without a flush, count %0d", count_o);

endmodule

`default_nettype wire

// File: hw/trdb_priority.sv
// ********************************************************
// packet priority
// picks format and subformat for the tc instruction
// ********************************************************
`timescale 1ns/1ps
`default_nettype none

module trdb_priority (
    input  logic                       fresh_i,
    input  trdb_cfg_pkg::trdb_stage_t  tc_i,
    input  trdb_cfg_pkg::trdb_stage_t  lc_i,
    input  logic                       lc_updiscon_i,
    input  logic                       map_full_i,
    output logic                       emit_o,
    output trdb_pkt_pkg::trdb_format_e format_o,
    output trdb_pkt_pkg::trdb_sync_e   subformat_o
);

    logic lc_first;

    // nothing traced before tc, so tc opens the trace
    assign lc_first = !lc_i.valid || !lc_i.qualified;

    always_comb begin
        emit_o      = 1'b0;
        format_o    = trdb_pkt_pkg::FMT_SYNC;
        subformat_o = trdb_pkt_pkg::SF_START;
        // one decision per instruction, only while tracing
        if (fresh_i && tc_i.qualified) begin
            if (lc_first) begin
                emit_o      = 1'b1;
                format_o    = trdb_pkt_pkg::FMT_SYNC;
                subformat_o = trdb_pkt_pkg::SF_START;
            end else if (lc_i.inst.exception) begin
                // tc is the first handler instruction
                emit_o      = 1'b1;
                format_o    = trdb_pkt_pkg::FMT_SYNC;
                subformat_o = trdb_pkt_pkg::SF_TRAP;
            end else if (lc_updiscon_i) begin
                // tc is the target of a jalr
                emit_o      = 1'b1;
                format_o    = trdb_pkt_pkg::FMT_ADDR;
            end else if (map_full_i) begin
                emit_o      = 1'b1;
                format_o    = trdb_pkt_pkg::FMT_BRANCH_FULL;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/trdb_packet_emitter.sv
// ********************************************************
// packet emitter
// builds the packet per format and registers it with a strobe
// ********************************************************
`timescale 1ns/1ps
`default_nettype none

module trdb_packet_emitter (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      emit_i,
    input  trdb_pkt_pkg::trdb_format_e                format_i,
    input  trdb_pkt_pkg::trdb_sync_e                  subformat_i,
    input  trdb_cfg_pkg::trdb_stage_t                 tc_i,
    input  trdb_cfg_pkg::trdb_stage_t                 lc_i,
    input  logic [trdb_pkt_pkg::BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [trdb_pkt_pkg::BRANCH_COUNT_LEN-1:0] count_i,
    output logic                                      packet_valid_o,
    output trdb_pkt_pkg::trdb_packet_t                packet_o
);

    trdb_pkt_pkg::trdb_packet_t packet_d;
    trdb_pkt_pkg::trdb_packet_t packet_q;
    logic                       valid_q;

    always_comb begin
        packet_d            = '0;
        packet_d.format     = format_i;
        // branch info goes out with every format
        packet_d.branches   = count_i;
        packet_d.branch_map = map_i;
        case (format_i)
            trdb_pkt_pkg::FMT_SYNC: begin
                packet_d.subformat = subformat_i;
                packet_d.priv      = tc_i.inst.priv;
                packet_d.address   = tc_i.inst.pc;
                // trap details come from the trapping instruction in lc
                if (subformat_i == trdb_pkt_pkg::SF_TRAP) begin
                    packet_d.interrupt = lc_i.inst.interrupt;
                    packet_d.cause     = lc_i.inst.cause;
                end
            end
            trdb_pkt_pkg::FMT_ADDR: begin
                packet_d.address = tc_i.inst.pc;
            end
            // branch-full carries no address
            default: begin
            end
        endcase
    end

    // strobe for exactly one cycle per emit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit_i;
        end
    end

    // packet held until the next emit
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_q <= packet_d;
        end
    end

    assign packet_valid_o = valid_q;
    assign packet_o       = packet_q;

    // branch-full only fires once the map holds every entry
    a_full_count: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (valid_q && packet_q.format == trdb_pkt_pkg::FMT_BRANCH_FULL)
            |-> (packet_q.branches == trdb_pkt_pkg::BRANCH_MAP_LEN)
    ) else $error("branch-full packet with %0d branches", packet_q.branches);

endmodule

`default_nettype wire

// File: hw/trace_debugger.sv
// ********************************************************
// trace encoder top
// nc/tc/lc instruction stages feeding the packet decision
// ********************************************************
`timescale 1ns/1ps
`default_nettype none

module trace_debugger (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       inst_valid_i,
    input  trdb_cfg_pkg::trdb_inst_t   inst_i,
    input  logic                       trace_enable_i,
    output logic                       packet_valid_o,
    output trdb_pkt_pkg::trdb_packet_t packet_o
);

    trdb_cfg_pkg::trdb_stage_t nc_q;
    trdb_cfg_pkg::trdb_stage_t tc_q;
    trdb_cfg_pkg::trdb_stage_t lc_q;
    logic                      lc_updiscon_q;
    logic                      tc_fresh_q;

    // type detection on tc
    logic tc_branch;
    logic tc_taken;
    logic tc_updiscon;

    // branch map
    logic                                      map_record;
    logic                                      map_flush;
    logic [trdb_pkt_pkg::BRANCH_MAP_LEN-1:0]   map;
    logic [trdb_pkt_pkg::BRANCH_COUNT_LEN-1:0] map_count;
    logic                                      map_full;

    // decision
    logic                       emit;
    trdb_pkt_pkg::trdb_format_e format;
    trdb_pkt_pkg::trdb_sync_e   subformat;

    // stages only move on a retired instruction, so tc always has its
    // successor sitting in nc
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_q          <= '0;
            tc_q          <= '0;
            lc_q          <= '0;
            lc_updiscon_q <= 1'b0;
            tc_fresh_q    <= 1'b0;
        end else begin
            // tc is decided exactly once, right after it arrives
            tc_fresh_q <= inst_valid_i && nc_q.valid;
            if (inst_valid_i) begin
                nc_q.inst      <= inst_i;
                nc_q.valid     <= 1'b1;
                nc_q.qualified <= trace_enable_i;
                tc_q           <= nc_q;
                lc_q           <= tc_q;
                lc_updiscon_q  <= tc_updiscon;
            end
        end
    end

    // trapping instructions do not retire, keep them out of the map
    assign map_record = tc_fresh_q && tc_q.qualified && tc_branch &&
                        !tc_q.inst.exception;

    // cleared by any packet and by an untraced instruction
    assign map_flush = emit || (tc_fresh_q && !tc_q.qualified);

    trdb_itype_detector i_trdb_itype_detector (
        .tc_data_i  (tc_q.inst.data),
        .tc_pc_i    (tc_q.inst.pc),
        .nc_pc_i    (nc_q.inst.pc),
        .branch_o   (tc_branch),
        .taken_o    (tc_taken),
        .updiscon_o (tc_updiscon)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .record_i (map_record),
        .taken_i  (tc_taken),
        .flush_i  (map_flush),
        .map_o    (map),
        .count_o  (map_count),
        .full_o   (map_full)
    );

    trdb_priority i_trdb_priority (
        .fresh_i       (tc_fresh_q),
        .tc_i          (tc_q),
        .lc_i          (lc_q),
        .lc_updiscon_i (lc_updiscon_q),
        .map_full_i    (map_full),
        .emit_o        (emit),
        .format_o      (format),
        .subformat_o   (subformat)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .emit_i         (emit),
        .format_i       (format),
        .subformat_i    (subformat),
        .tc_i           (tc_q),
        .lc_i           (lc_q),
        .map_i          (map),
        .count_i        (map_count),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

endmodule

`default_nettype wire

// File: bench/tb_trace_debugger.sv
// ************************************************************
// testbench for the trace encoder top
// table of retired instructions against a scoreboard of packets
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_trace_debugger;

    // expected packet kind attached to a table row
    typedef enum logic [2:0] {
        EXP_NONE,
        EXP_START,
        EXP_TRAP,
        EXP_ADDR,
        EXP_FULL
    } exp_e;

    typedef struct packed {
        trdb_cfg_pkg::trdb_inst_t inst;
        logic                     en;
        exp_e                     exp;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       inst_valid;
    trdb_cfg_pkg::trdb_inst_t   inst;
    logic                       trace_enable;
    logic                       packet_valid;
    trdb_pkt_pkg::trdb_packet_t packet;

    row_t                       rows[$];
    trdb_pkt_pkg::trdb_packet_t exp_q[$];
    trdb_pkt_pkg::trdb_packet_t exp_pkt;
    int                         value_errors;
    int                         other_errors;
    logic                       started;

    trace_debugger UUT (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst),
        .trace_enable_i (trace_enable),
        .packet_valid_o (packet_valid),
        .packet_o       (packet)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic void add_row(input logic [31:0] pc, input logic [6:0] op,
            input logic exc, input logic intr, input logic [4:0] cause,
            input logic [1:0] priv, input logic en, input exp_e exp);
        row_t r;
        r                = '0;
        r.inst.pc        = pc;
        r.inst.data      = {25'd0, op};
        r.inst.exception = exc;
        r.inst.interrupt = intr;
        r.inst.cause     = cause;
        r.inst.priv      = priv;
        r.en             = en;
        r.exp            = exp;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        logic [31:0] pc;
        int          i;
        // start sync, two branches, jal, jalr, then address packet
        add_row(32'h1000, 7'h13, 0, 0, 0, 2'd1, 1, EXP_START);
        add_row(32'h1004, 7'h13, 0, 0, 0, 2'd1, 1, EXP_NONE);
        add_row(32'h1008, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd1, 1, EXP_NONE);
        add_row(32'h1010, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd1, 1, EXP_NONE);
        add_row(32'h1014, trdb_cfg_pkg::OPC_JAL, 0, 0, 0, 2'd1, 1, EXP_NONE);
        add_row(32'h1800, trdb_cfg_pkg::OPC_JALR, 0, 0, 0, 2'd1, 1, EXP_NONE);
        add_row(32'h2000, 7'h13, 0, 0, 0, 2'd1, 1, EXP_ADDR);
        // exception then handler, interrupt then handler
        add_row(32'h2004, 7'h13, 1, 0, 5'd2, 2'd1, 1, EXP_NONE);
        add_row(32'h0100, 7'h13, 0, 0, 0, 2'd3, 1, EXP_TRAP);
        add_row(32'h0104, 7'h13, 1, 1, 5'd7, 2'd3, 1, EXP_NONE);
        add_row(32'h0200, 7'h13, 0, 0, 0, 2'd3, 1, EXP_TRAP);
        // branch left in the map, then tracing off for three rows
        add_row(32'h0204, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd3, 1, EXP_NONE);
        add_row(32'h0208, 7'h13, 0, 0, 0, 2'd3, 0, EXP_NONE);
        add_row(32'h020c, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd3, 0, EXP_NONE);
        add_row(32'h0214, 7'h13, 0, 0, 0, 2'd3, 0, EXP_NONE);
        add_row(32'h0218, 7'h13, 0, 0, 0, 2'd0, 1, EXP_START);
        // 32 branches, every third one taken
        pc = 32'h3000;
        for (i = 0; i < 32; i++) begin
            if (i == 30) begin
                add_row(pc, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd0, 1, EXP_FULL);
            end else begin
                add_row(pc, trdb_cfg_pkg::OPC_BRANCH, 0, 0, 0, 2'd0, 1, EXP_NONE);
            end
            pc = pc + (((i % 3) == 0) ? 32'd8 : 32'd4);
        end
        // leftover branch shows up in the next address packet
        add_row(pc, trdb_cfg_pkg::OPC_JALR, 0, 0, 0, 2'd0, 1, EXP_NONE);
        add_row(32'h4000, 7'h13, 0, 0, 0, 2'd0, 1, EXP_ADDR);
        // successor so the row above gets decided
        add_row(32'h4004, 7'h13, 0, 0, 0, 2'd0, 1, EXP_NONE);
    endfunction

    // reference model of the packet rules, run over the whole table
    function automatic void predict_packets();
        logic [30:0]                map;
        int                         cnt;
        int                         k;
        logic                       taken;
        trdb_pkt_pkg::trdb_packet_t p;
        map = '0;
        cnt = 0;
        // last row has no successor and is never decided
        for (k = 0; k + 1 < rows.size(); k++) begin
            if (!rows[k].en) begin
                map = '0;
                cnt = 0;
            end else begin
                if (rows[k].inst.data[6:0] == trdb_cfg_pkg::OPC_BRANCH &&
                        !rows[k].inst.exception) begin
                    taken    = rows[k+1].inst.pc != rows[k].inst.pc + 32'd4;
                    map[cnt] = !taken;
                    cnt++;
                end
                if (rows[k].exp != EXP_NONE) begin
                    p            = '0;
                    p.branches   = 5'(cnt);
                    p.branch_map = map;
                    case (rows[k].exp)
                        EXP_START, EXP_TRAP: begin
                            p.format  = trdb_pkt_pkg::FMT_SYNC;
                            p.priv    = rows[k].inst.priv;
                            p.address = rows[k].inst.pc;
                            if (rows[k].exp == EXP_TRAP) begin
                                p.subformat = trdb_pkt_pkg::SF_TRAP;
                                p.interrupt = rows[k-1].inst.interrupt;
                                p.cause     = rows[k-1].inst.cause;
                            end
                        end
                        EXP_ADDR: begin
                            p.format  = trdb_pkt_pkg::FMT_ADDR;
                            p.address = rows[k].inst.pc;
                        end
                        default: begin
                            p.format = trdb_pkt_pkg::FMT_BRANCH_FULL;
                        end
                    endcase
                    exp_q.push_back(p);
                    map = '0;
                    cnt = 0;
                end
            end
        end
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
            input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, want);
            value_errors++;
        end
    endtask

    // scoreboard, outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && packet_valid) begin
            if (!started) begin
                $display("packet strobe seen before any instruction was driven");
                other_errors++;
            end else if (exp_q.size() == 0) begin
                $display("packet strobe seen with no packet left to expect");
                other_errors++;
            end else begin
                exp_pkt = exp_q.pop_front();
                check_field("packet_o.format", 32'(packet.format), 32'(exp_pkt.format));
                check_field("packet_o.subformat", 32'(packet.subformat),
                            32'(exp_pkt.subformat));
                check_field("packet_o.priv", 32'(packet.priv), 32'(exp_pkt.priv));
                check_field("packet_o.interrupt", 32'(packet.interrupt),
                            32'(exp_pkt.interrupt));
                check_field("packet_o.cause", 32'(packet.cause), 32'(exp_pkt.cause));
                check_field("packet_o.address", packet.address, exp_pkt.address);
                check_field("packet_o.branches", 32'(packet.branches),
                            32'(exp_pkt.branches));
                check_field("packet_o.branch_map", 32'(packet.branch_map),
                            32'(exp_pkt.branch_map));
            end
        end
    end

    initial begin
        int unsigned gap;
        int          i;
        int          wait_cnt;
        void'($urandom(16932));
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        trace_enable = 1'b0;
        value_errors = 0;
        other_errors = 0;
        started      = 1'b0;
        build_table();
        predict_packets();
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        // quiet stretch, no packet may appear here
        repeat (4) @(posedge clk);
        for (i = 0; i < rows.size(); i++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #10 inst_valid = 1'b0;
                inst = '0;
            end
            @(posedge clk);
            #10 started = 1'b1;
            inst_valid   = 1'b1;
            inst         = rows[i].inst;
            trace_enable = rows[i].en;
        end
        @(posedge clk);
        #10 inst_valid = 1'b0;
        // drain the scoreboard
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 100) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d expected packets still missing", exp_q.size());
            other_errors++;
        end
        // a few more cycles to catch stray packets
        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/trdb_cfg_pkg.sv
hw/trdb_pkt_pkg.sv
hw/trdb_itype_detector.sv
hw/trdb_branch_map.sv
hw/trdb_priority.sv
hw/trdb_packet_emitter.sv
hw/trace_debugger.sv
bench/tb_trace_debugger.sv
